// ==== cu_control.f ====
hw/cu_sizes_pkg.sv
hw/cu_bus_pkg.sv
hw/cu_config_regs.sv
hw/read_arbiter.sv
hw/response_router.sv
hw/completion_tracker.sv
hw/cu_control.sv
test/cu_checker.sv
test/tb_cu_control.sv

// ==== hw/completion_tracker.sv ====
// Counts delivered vertex and edge records against the descriptor totals.
// Done is sticky until reset. Counters do not wrap-protect, so
// COUNT_WIDTH must cover the largest total.
`timescale 1ns/10ps
`default_nettype none

module completion_tracker #(
	parameter int COUNT_WIDTH = 32
) (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  logic                                   cu_ready,
	input  logic                                   vertex_job_resp_valid,
	input  logic                                   algorithm_resp_valid,
	input  logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] total_vertices,
	input  logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] total_edges,
	output logic                                   cu_done,
	output logic [COUNT_WIDTH-1:0]                 cu_return_vertices,
	output logic [COUNT_WIDTH-1:0]                 cu_return_edges
);

	// compare at the wider of the two widths
	localparam int CMP_WIDTH = (COUNT_WIDTH > cu_sizes_pkg::WED_COUNT_WIDTH) ?
		COUNT_WIDTH : cu_sizes_pkg::WED_COUNT_WIDTH;

	logic [CMP_WIDTH-1:0] vertices_seen;
	logic [CMP_WIDTH-1:0] edges_seen;
	logic [CMP_WIDTH-1:0] vertices_total;
	logic [CMP_WIDTH-1:0] edges_total;

	assign vertices_seen  = CMP_WIDTH'(cu_return_vertices);
	assign edges_seen     = CMP_WIDTH'(cu_return_edges);
	assign vertices_total = CMP_WIDTH'(total_vertices);
	assign edges_total    = CMP_WIDTH'(total_edges);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_return_vertices <= '0;
			cu_return_edges    <= '0;
			cu_done            <= 1'b0;
		end else begin
			if (vertex_job_resp_valid)
				cu_return_vertices <= cu_return_vertices + COUNT_WIDTH'(1);
			if (algorithm_resp_valid)
				cu_return_edges <= cu_return_edges + COUNT_WIDTH'(1);
			if (cu_ready && (vertices_seen == vertices_total) && (edges_seen == edges_total))
				cu_done <= 1'b1;
		end
	end

	// clients must never read past the descriptor
	no_overrun: assert property (@(posedge clock) disable iff (!rstn)
		cu_ready |-> (vertices_seen <= vertices_total) && (edges_seen <= edges_total))
		else $error("delivered records exceed descriptor totals");

endmodule

`default_nettype wire

// ==== hw/cu_bus_pkg.sv ====
// Bus and record types of the compute unit control hub.
// Both record views are exactly one 64-bit bus word, upper field first.
`default_nettype none

package cu_bus_pkg;

	// requester of a read and destination of its response
	typedef enum logic {
		CLIENT_VERTEX_JOB = 1'b0,
		CLIENT_ALGORITHM  = 1'b1
	} client_id_t;

	// vertex array entry as the vertex-job reader sees it
	typedef struct packed {
		logic [31:0] out_degree;
		logic [31:0] edge_offset;
	} vertex_record_t;

	// edge array entry as the graph-algorithm reader sees it
	typedef struct packed {
		logic [31:0] dest_vertex;
		logic [31:0] weight;
	} edge_record_t;

	// one returned word, decoded by whichever client asked for it
	typedef union packed {
		vertex_record_t as_vertex;
		edge_record_t   as_edge;
	} response_word_u;

endpackage

`default_nettype wire

// ==== hw/cu_config_regs.sv ====
// Configuration and work descriptor latch.
// Inputs are sampled only while enabled is high. A zero configuration word
// is ignored, so once configured the unit stays configured until reset.
`timescale 1ns/10ps
`default_nettype none

module cu_config_regs (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  logic                                   enabled,
	input  logic [cu_sizes_pkg::CONFIG_WIDTH-1:0]    config_word,
	input  logic                                   wed_valid,
	input  logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] wed_num_vertices,
	input  logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] wed_num_edges,
	output logic                                   cu_ready,
	output logic [cu_sizes_pkg::CONFIG_WIDTH-1:0]    cu_status,
	output logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] total_vertices,
	output logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] total_edges
);

	logic wed_captured;

	// keep the last nonzero word seen while enabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_status <= '0;
		end else if (enabled && (|config_word)) begin
			cu_status <= config_word;
		end
	end

	// a later descriptor replaces the earlier totals
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_captured   <= 1'b0;
			total_vertices <= '0;
			total_edges    <= '0;
		end else if (enabled && wed_valid) begin
			wed_captured   <= 1'b1;
			total_vertices <= wed_num_vertices;
			total_edges    <= wed_num_edges;
		end
	end

	assign cu_ready = (|cu_status) && wed_captured;

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// neither register can return to its empty state without reset
	ready_holds: assert property (@(posedge clock) disable iff (!rstn)
		cu_ready |=> cu_ready)
		else $error("cu_ready fell after it had risen");

endmodule

`default_nettype wire

// ==== hw/cu_control.sv ====
// Control hub of one graph-processing compute unit.
// Two read clients share one Wishbone classic read-only master port.
// Nothing moves on the bus until a nonzero configuration and a descriptor
// have both been captured while enabled.
`timescale 1ns/10ps
`default_nettype none

module cu_control #(
	parameter int COUNT_WIDTH = 32
) (
	input  logic                                   clock,
	input  logic                                   rstn,
	// enable, configuration and work descriptor
	input  logic                                   enabled,
	input  logic [cu_sizes_pkg::CONFIG_WIDTH-1:0]    config_word,
	input  logic                                   wed_valid,
	input  logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] wed_num_vertices,
	input  logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] wed_num_edges,
	// client requests
	input  logic                                   vertex_job_req,
	input  logic [cu_sizes_pkg::ADDR_WIDTH-1:0]      vertex_job_addr,
	output logic                                   vertex_job_grant,
	input  logic                                   algorithm_req,
	input  logic [cu_sizes_pkg::ADDR_WIDTH-1:0]      algorithm_addr,
	output logic                                   algorithm_grant,
	// Wishbone classic master, read only
	output logic                                   wb_cyc,
	output logic                                   wb_stb,
	output logic [cu_sizes_pkg::ADDR_WIDTH-1:0]      wb_adr,
	input  logic                                   wb_ack,
	input  logic [cu_sizes_pkg::DATA_WIDTH-1:0]      wb_dat_i,
	// client responses
	output logic                                   vertex_job_resp_valid,
	output cu_bus_pkg::vertex_record_t             vertex_job_record,
	output logic                                   algorithm_resp_valid,
	output cu_bus_pkg::edge_record_t               algorithm_record,
	// status
	output logic [cu_sizes_pkg::CONFIG_WIDTH-1:0]    cu_status,
	output logic                                   cu_done,
	output logic [COUNT_WIDTH-1:0]                 cu_return_vertices,
	output logic [COUNT_WIDTH-1:0]                 cu_return_edges
);

	logic                                   cu_ready;
	logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] total_vertices;
	logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] total_edges;
	logic                                   fetch_valid;
	cu_bus_pkg::response_word_u             fetch_word;
	cu_bus_pkg::client_id_t                 fetch_client;

	cu_config_regs config_regs (
		.clock(clock), .rstn(rstn), .enabled(enabled), .config_word(config_word),
		.wed_valid(wed_valid), .wed_num_vertices(wed_num_vertices),
		.wed_num_edges(wed_num_edges), .cu_ready(cu_ready), .cu_status(cu_status),
		.total_vertices(total_vertices), .total_edges(total_edges)
	);

	read_arbiter arbiter (
		.clock(clock), .rstn(rstn), .cu_ready(cu_ready),
		.vertex_job_req(vertex_job_req), .vertex_job_addr(vertex_job_addr),
		.algorithm_req(algorithm_req), .algorithm_addr(algorithm_addr),
		.wb_ack(wb_ack), .wb_dat_i(wb_dat_i),
		.vertex_job_grant(vertex_job_grant), .algorithm_grant(algorithm_grant),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
		.fetch_valid(fetch_valid), .fetch_word(fetch_word), .fetch_client(fetch_client)
	);

	response_router router (
		.clock(clock), .rstn(rstn), .fetch_valid(fetch_valid),
		.fetch_word(fetch_word), .fetch_client(fetch_client),
		.vertex_job_resp_valid(vertex_job_resp_valid), .vertex_job_record(vertex_job_record),
		.algorithm_resp_valid(algorithm_resp_valid), .algorithm_record(algorithm_record)
	);

	completion_tracker #(
		.COUNT_WIDTH(COUNT_WIDTH)
	) tracker (
		.clock(clock), .rstn(rstn), .cu_ready(cu_ready),
		.vertex_job_resp_valid(vertex_job_resp_valid),
		.algorithm_resp_valid(algorithm_resp_valid),
		.total_vertices(total_vertices), .total_edges(total_edges),
		.cu_done(cu_done), .cu_return_vertices(cu_return_vertices),
		.cu_return_edges(cu_return_edges)
	);

endmodule

`default_nettype wire

// ==== hw/cu_sizes_pkg.sv ====
// Sizes shared by the compute unit control hub.
// The Wishbone address is a byte address. Only full 64-bit words are read.
// Descriptor totals are unsigned record counts.
`default_nettype none

package cu_sizes_pkg;

	//////////////////////////////////////////////////////////////////////
	// memory read port
	//////////////////////////////////////////////////////////////////////

	// byte address on the Wishbone master
	localparam int ADDR_WIDTH = 32;

	// one returned word, one vertex or edge record
	localparam int DATA_WIDTH = 64;

	//////////////////////////////////////////////////////////////////////
	// configuration and work descriptor
	//////////////////////////////////////////////////////////////////////

	// zero means not configured
	localparam int CONFIG_WIDTH = 64;

	// vertex and edge totals carried by the descriptor
	localparam int WED_COUNT_WIDTH = 32;

endpackage

`default_nettype wire

// ==== hw/read_arbiter.sv ====
// Round-robin read arbiter onto one Wishbone classic master.
// One cycle is in flight at a time and the master never writes.
// Clients hold req and address until their one-cycle grant, which marks ack.
// After reset the vertex-job client wins a tie.
`timescale 1ns/10ps
`default_nettype none

module read_arbiter (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              cu_ready,
	input  logic                              vertex_job_req,
	input  logic [cu_sizes_pkg::ADDR_WIDTH-1:0] vertex_job_addr,
	input  logic                              algorithm_req,
	input  logic [cu_sizes_pkg::ADDR_WIDTH-1:0] algorithm_addr,
	input  logic                              wb_ack,
	input  logic [cu_sizes_pkg::DATA_WIDTH-1:0] wb_dat_i,
	output logic                              vertex_job_grant,
	output logic                              algorithm_grant,
	output logic                              wb_cyc,
	output logic                              wb_stb,
	output logic [cu_sizes_pkg::ADDR_WIDTH-1:0] wb_adr,
	output logic                              fetch_valid,
	output cu_bus_pkg::response_word_u        fetch_word,
	output cu_bus_pkg::client_id_t            fetch_client
);

	cu_bus_pkg::client_id_t owner;
	cu_bus_pkg::client_id_t last_served;
	cu_bus_pkg::client_id_t pick;
	logic                   vertex_job_pending;
	logic                   algorithm_pending;
	logic                   start;
	logic                   done;

	// a client under grant this cycle still shows the request it was served for
	assign vertex_job_pending = vertex_job_req && !vertex_job_grant;
	assign algorithm_pending  = algorithm_req && !algorithm_grant;
	assign start = cu_ready && !wb_cyc && (vertex_job_pending || algorithm_pending);
	assign done  = wb_cyc && wb_ack;

	always_comb begin
		if (vertex_job_pending && algorithm_pending) begin
			pick = (last_served == cu_bus_pkg::CLIENT_VERTEX_JOB) ?
				cu_bus_pkg::CLIENT_ALGORITHM : cu_bus_pkg::CLIENT_VERTEX_JOB;
		end else if (algorithm_pending) begin
			pick = cu_bus_pkg::CLIENT_ALGORITHM;
		end else begin
			pick = cu_bus_pkg::CLIENT_VERTEX_JOB;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bus cycle, grants and hand-off to the router
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wb_cyc           <= 1'b0;
			wb_stb           <= 1'b0;
			wb_adr           <= '0;
			owner            <= cu_bus_pkg::CLIENT_VERTEX_JOB;
			last_served      <= cu_bus_pkg::CLIENT_ALGORITHM;
			vertex_job_grant <= 1'b0;
			algorithm_grant  <= 1'b0;
			fetch_valid      <= 1'b0;
		end else begin
			vertex_job_grant <= 1'b0;
			algorithm_grant  <= 1'b0;
			fetch_valid      <= 1'b0;
			if (start) begin
				wb_cyc <= 1'b1;
				wb_stb <= 1'b1;
				owner  <= pick;
				wb_adr <= (pick == cu_bus_pkg::CLIENT_VERTEX_JOB) ?
					vertex_job_addr : algorithm_addr;
			end else if (done) begin
				wb_cyc           <= 1'b0;
				wb_stb           <= 1'b0;
				last_served      <= owner;
				fetch_valid      <= 1'b1;
				vertex_job_grant <= (owner == cu_bus_pkg::CLIENT_VERTEX_JOB);
				algorithm_grant  <= (owner == cu_bus_pkg::CLIENT_ALGORITHM);
			end
		end
	end

	// data word and owner only mean something next to fetch_valid
	always_ff @(posedge clock) begin
		if (done) begin
			fetch_word   <= cu_bus_pkg::response_word_u'(wb_dat_i);
			fetch_client <= owner;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	adr_stable: assert property (@(posedge clock) disable iff (!rstn)
		(wb_stb && !wb_ack) |=> $stable(wb_adr))
		else $error("wb_adr changed while waiting for ack");

	grant_onehot: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_job_grant && algorithm_grant))
		else $error("both clients granted in one cycle");

	stb_in_cyc: assert property (@(posedge clock) disable iff (!rstn)
		wb_stb |-> wb_cyc)
		else $error("wb_stb high outside a bus cycle");

endmodule

`default_nettype wire

// ==== hw/response_router.sv ====
// Steers each fetched word to the client that asked for it, one cycle later.
// The record of the client not addressed is driven to zero.
`timescale 1ns/10ps
`default_nettype none

module response_router (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       fetch_valid,
	input  cu_bus_pkg::response_word_u fetch_word,
	input  cu_bus_pkg::client_id_t     fetch_client,
	output logic                       vertex_job_resp_valid,
	output cu_bus_pkg::vertex_record_t vertex_job_record,
	output logic                       algorithm_resp_valid,
	output cu_bus_pkg::edge_record_t   algorithm_record
);

	logic to_vertex_job;
	logic to_algorithm;

	assign to_vertex_job = fetch_valid && (fetch_client == cu_bus_pkg::CLIENT_VERTEX_JOB);
	assign to_algorithm  = fetch_valid && (fetch_client == cu_bus_pkg::CLIENT_ALGORITHM);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_resp_valid <= 1'b0;
			vertex_job_record     <= '0;
			algorithm_resp_valid  <= 1'b0;
			algorithm_record      <= '0;
		end else begin
			vertex_job_resp_valid <= to_vertex_job;
			algorithm_resp_valid  <= to_algorithm;
			// same 64 bits, read through each client's own view
			vertex_job_record <= to_vertex_job ? fetch_word.as_vertex : '0;
			algorithm_record  <= to_algorithm ? fetch_word.as_edge : '0;
		end
	end

	resp_exclusive: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_job_resp_valid && algorithm_resp_valid))
		else $error("one word delivered to both clients");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it once.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Mdir obj_dir \
	--top-module tb_cu_control -f cu_control.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_cu_control)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

// ==== test/cu_checker.sv ====
// Watches the DUT ports and compares them with a model of the hub.
// Everything is sampled on the rising edge, before the DUT registers update.
// Tests are marked by the phase number that the testbench top drives.
`timescale 1ns/10ps
`default_nettype none

module cu_checker (
	input  logic                                     clock,
	input  logic                                     rstn,
	input  int                                       phase,
	input  logic                                     enabled,
	input  logic [cu_sizes_pkg::CONFIG_WIDTH-1:0]    config_word,
	input  logic                                     wed_valid,
	input  logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] wed_num_vertices,
	input  logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] wed_num_edges,
	input  logic                                     vertex_job_req,
	input  logic [cu_sizes_pkg::ADDR_WIDTH-1:0]      vertex_job_addr,
	input  logic                                     vertex_job_grant,
	input  logic                                     algorithm_req,
	input  logic [cu_sizes_pkg::ADDR_WIDTH-1:0]      algorithm_addr,
	input  logic                                     algorithm_grant,
	input  logic                                     wb_cyc,
	input  logic                                     wb_stb,
	input  logic [cu_sizes_pkg::ADDR_WIDTH-1:0]      wb_adr,
	input  logic                                     wb_ack,
	input  logic [cu_sizes_pkg::DATA_WIDTH-1:0]      wb_dat_i,
	input  logic                                     vertex_job_resp_valid,
	input  cu_bus_pkg::vertex_record_t               vertex_job_record,
	input  logic                                     algorithm_resp_valid,
	input  cu_bus_pkg::edge_record_t                 algorithm_record,
	input  logic [cu_sizes_pkg::CONFIG_WIDTH-1:0]    cu_status,
	input  logic                                     cu_done,
	input  logic [31:0]                              cu_return_vertices,
	input  logic [31:0]                              cu_return_edges,
	output int                                       errors
);

	localparam int END_PHASE = 6;

	// configuration and completion model
	logic [cu_sizes_pkg::CONFIG_WIDTH-1:0]    status_m;
	logic                                     wed_seen;
	logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] total_v;
	logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] total_e;
	logic [31:0]                              count_v;
	logic [31:0]                              count_e;
	logic                                     done_m;
	logic                                     ready_m;
	// arbitration model
	cu_bus_pkg::client_id_t                   last_served;
	cu_bus_pkg::client_id_t                   cur_owner;
	cu_bus_pkg::client_id_t                   next_owner;
	logic [cu_sizes_pkg::ADDR_WIDTH-1:0]      cur_addr;
	logic [cu_sizes_pkg::ADDR_WIDTH-1:0]      next_addr;
	logic                                     open_due;
	logic                                     prev_cyc;
	logic                                     pend_v;
	logic                                     pend_a;
	// acked words, one and two cycles back
	logic                                     ack_d1;
	logic                                     ack_d2;
	cu_bus_pkg::client_id_t                   owner_d1;
	cu_bus_pkg::client_id_t                   owner_d2;
	logic [cu_sizes_pkg::DATA_WIDTH-1:0]      data_d1;
	logic [cu_sizes_pkg::DATA_WIDTH-1:0]      data_d2;
	int                                       prev_phase;
	int                                       test_checks;
	int                                       test_errors;
	int                                       all_checks;

	task automatic compare(input logic ok, input string what);
		all_checks++;
		test_checks++;
		if (!ok) begin
			errors++;
			test_errors++;
			$display("mismatch at %0d ns: %s", $time, what);
		end
	endtask

	function automatic string test_name(input int n);
		case (n)
			1: return "configuration";
			2: return "round robin, both clients";
			3: return "single requester";
			4: return "random traffic";
			default: return "completion";
		endcase
	endfunction

	always @(posedge clock) begin
		if (!rstn) begin
			status_m    = '0;
			wed_seen    = 1'b0;
			total_v     = '0;
			total_e     = '0;
			count_v     = '0;
			count_e     = '0;
			done_m      = 1'b0;
			last_served = cu_bus_pkg::CLIENT_ALGORITHM;
			cur_owner   = cu_bus_pkg::CLIENT_VERTEX_JOB;
			cur_addr    = '0;
			open_due    = 1'b0;
			prev_cyc    = 1'b0;
			ack_d1      = 1'b0;
			ack_d2      = 1'b0;
			errors      = 0;
			all_checks  = 0;
			prev_phase  = 0;
		end else begin
			ready_m = (|status_m) && wed_seen;
			// a client under grant shows the request it was just served for
			pend_v = vertex_job_req && !vertex_job_grant;
			pend_a = algorithm_req && !algorithm_grant;

			compare(cu_status == status_m, "cu_status is not the last accepted config word");
			compare(cu_return_vertices == count_v, "cu_return_vertices differs from model");
			compare(cu_return_edges == count_e, "cu_return_edges differs from model");
			compare(cu_done == done_m, "cu_done differs from model");
			compare(!(wb_cyc && !ready_m), "bus cycle open before config and descriptor");
			compare(wb_stb == wb_cyc, "wb_stb and wb_cyc differ");

			////////////////////////////////////////////////////////////////////
			// bus cycle, grants and responses
			////////////////////////////////////////////////////////////////////
			if (open_due) begin
				compare(wb_cyc, "no bus cycle opened for a pending request");
				compare(wb_adr == next_addr, "wb_adr is not the chosen client's address");
				cur_owner = next_owner;
				cur_addr  = next_addr;
			end else if (wb_cyc && !prev_cyc) begin
				compare(1'b0, "bus cycle opened with no pending request");
			end else if (wb_cyc) begin
				compare(wb_adr == cur_addr, "wb_adr changed before ack");
			end
			// an open cycle waits for its ack
			if (prev_cyc && !ack_d1)
				compare(wb_cyc, "bus cycle ended before ack");
			if (ack_d1)
				compare(!wb_cyc, "wb_cyc still high one cycle after ack");
			compare(vertex_job_grant == (ack_d1 && owner_d1 == cu_bus_pkg::CLIENT_VERTEX_JOB),
				"vertex-job grant does not follow its acked cycle");
			compare(algorithm_grant == (ack_d1 && owner_d1 == cu_bus_pkg::CLIENT_ALGORITHM),
				"algorithm grant does not follow its acked cycle");
			compare(vertex_job_resp_valid == (ack_d2 && owner_d2 == cu_bus_pkg::CLIENT_VERTEX_JOB),
				"vertex-job response valid at the wrong time");
			compare(algorithm_resp_valid == (ack_d2 && owner_d2 == cu_bus_pkg::CLIENT_ALGORITHM),
				"algorithm response valid at the wrong time");
			if (vertex_job_resp_valid)
				compare(vertex_job_record.out_degree == data_d2[63:32] &&
					vertex_job_record.edge_offset == data_d2[31:0],
					"vertex record fields differ from the returned word");
			else
				compare(vertex_job_record == '0, "idle vertex record is not zero");
			if (algorithm_resp_valid)
				compare(algorithm_record.dest_vertex == data_d2[63:32] &&
					algorithm_record.weight == data_d2[31:0],
					"edge record fields differ from the returned word");
			else
				compare(algorithm_record == '0, "idle edge record is not zero");

			// done follows the counts one cycle later and then holds
			if (ready_m && count_v == total_v && count_e == total_e)
				done_m = 1'b1;
			if (ack_d2 && owner_d2 == cu_bus_pkg::CLIENT_VERTEX_JOB)
				count_v = count_v + 32'd1;
			if (ack_d2 && owner_d2 == cu_bus_pkg::CLIENT_ALGORITHM)
				count_e = count_e + 32'd1;

			ack_d2   = ack_d1;
			owner_d2 = owner_d1;
			data_d2  = data_d1;
			ack_d1   = wb_cyc && wb_ack;
			owner_d1 = cur_owner;
			data_d1  = wb_dat_i;
			if (ack_d1)
				last_served = cur_owner;

			// round robin, the client not served last wins a tie
			open_due = !wb_cyc && ready_m && (pend_v || pend_a);
			if (pend_v && pend_a)
				next_owner = (last_served == cu_bus_pkg::CLIENT_VERTEX_JOB) ?
					cu_bus_pkg::CLIENT_ALGORITHM : cu_bus_pkg::CLIENT_VERTEX_JOB;
			else if (pend_a)
				next_owner = cu_bus_pkg::CLIENT_ALGORITHM;
			else
				next_owner = cu_bus_pkg::CLIENT_VERTEX_JOB;
			next_addr = (next_owner == cu_bus_pkg::CLIENT_VERTEX_JOB) ?
				vertex_job_addr : algorithm_addr;

			if (enabled && (|config_word))
				status_m = config_word;
			if (enabled && wed_valid) begin
				wed_seen = 1'b1;
				total_v  = wed_num_vertices;
				total_e  = wed_num_edges;
			end
			prev_cyc = wb_cyc;
		end

		// close the running test when the phase moves on
		if (phase != prev_phase) begin
			if (prev_phase != 0)
				$display("test %0d %s: %0d checks, %0d errors", prev_phase,
					test_name(prev_phase), test_checks, test_errors);
			if (phase == END_PHASE)
				$display("tests %0d, checks %0d, errors %0d", END_PHASE - 1, all_checks, errors);
			test_checks = 0;
			test_errors = 0;
			prev_phase  = phase;
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_cu_control.sv ====
// Testbench for the compute unit control hub.
// Two random read clients and a Wishbone slave with 0 to 4 wait states
// drive the DUT. Inputs change 1 ns after the rising edge, seed is fixed.
`timescale 1ns/10ps
`default_nettype none

module tb_cu_control;

	localparam int PERIOD       = 10;
	localparam int SEED         = 20;
	localparam int BOTH_COUNT   = 12;
	localparam int SINGLE_COUNT = 6;
	localparam int RANDOM_COUNT = 10;
	// the request held during configuration is one more vertex record
	localparam int TOTAL_V = 1 + BOTH_COUNT + SINGLE_COUNT + RANDOM_COUNT;
	localparam int TOTAL_E = BOTH_COUNT + SINGLE_COUNT + RANDOM_COUNT;
	// open, wait states, ack, gap and client idle, with room to spare
	localparam int MAX_CYCLES = 12;
	localparam int MARGIN     = 200;
	localparam int TIMEOUT_NS = ((TOTAL_V + TOTAL_E) * MAX_CYCLES + MARGIN) * PERIOD;

	logic                                     clock;
	logic                                     rstn;
	logic                                     enabled;
	logic [cu_sizes_pkg::CONFIG_WIDTH-1:0]    config_word;
	logic                                     wed_valid;
	logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] wed_num_vertices;
	logic [cu_sizes_pkg::WED_COUNT_WIDTH-1:0] wed_num_edges;
	logic                                     vertex_job_req;
	logic [cu_sizes_pkg::ADDR_WIDTH-1:0]      vertex_job_addr;
	logic                                     vertex_job_grant;
	logic                                     algorithm_req;
	logic [cu_sizes_pkg::ADDR_WIDTH-1:0]      algorithm_addr;
	logic                                     algorithm_grant;
	logic                                     wb_cyc;
	logic                                     wb_stb;
	logic [cu_sizes_pkg::ADDR_WIDTH-1:0]      wb_adr;
	logic                                     wb_ack;
	logic [cu_sizes_pkg::DATA_WIDTH-1:0]      wb_dat_i;
	logic                                     vertex_job_resp_valid;
	cu_bus_pkg::vertex_record_t               vertex_job_record;
	logic                                     algorithm_resp_valid;
	cu_bus_pkg::edge_record_t                 algorithm_record;
	logic [cu_sizes_pkg::CONFIG_WIDTH-1:0]    cu_status;
	logic                                     cu_done;
	logic [31:0]                              cu_return_vertices;
	logic [31:0]                              cu_return_edges;
	int                                       phase;
	int                                       errors;

	cu_control uut (.*);

	cu_checker check_unit (.*);

	// the top address bit tags the client the address belongs to
	function automatic logic [31:0] make_addr(input logic to_alg);
		logic [31:0] r;
		r = $urandom();
		return {to_alg, r[30:3], 3'b000};
	endfunction

	// one client issuing count requests, each held until its grant
	task automatic run_client(input logic to_alg, input int count, input int idle_max);
		int idle;
		repeat (count) begin
			idle = $urandom_range(idle_max, 0);
			repeat (idle) begin
				@(posedge clock);
				#1;
			end
			if (to_alg) begin
				algorithm_addr = make_addr(1'b1);
				algorithm_req  = 1'b1;
			end else begin
				vertex_job_addr = make_addr(1'b0);
				vertex_job_req  = 1'b1;
			end
			do begin
				@(posedge clock);
				#1;
			end while (to_alg ? !algorithm_grant : !vertex_job_grant);
			if (to_alg)
				algorithm_req = 1'b0;
			else
				vertex_job_req = 1'b0;
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// Wishbone slave, random wait states and random data
	initial begin
		int delay;
		wb_ack   = 1'b0;
		wb_dat_i = '0;
		forever begin
			@(posedge clock);
			#1;
			wb_ack = 1'b0;
			if (wb_cyc) begin
				delay = $urandom_range(4, 0);
				repeat (delay) begin
					@(posedge clock);
					#1;
				end
				wb_ack   = 1'b1;
				wb_dat_i = {$urandom(), $urandom()};
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the planned transfers did not complete in %0d ns", TIMEOUT_NS);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		rstn             = 1'b0;
		enabled          = 1'b0;
		config_word      = '0;
		wed_valid        = 1'b0;
		wed_num_vertices = '0;
		wed_num_edges    = '0;
		vertex_job_req   = 1'b0;
		vertex_job_addr  = '0;
		algorithm_req    = 1'b0;
		algorithm_addr   = '0;
		phase            = 0;
		repeat (2) @(posedge clock);
		#1;
		rstn = 1'b1;

		////////////////////////////////////////////////////////////////////////
		// configuration, with a request waiting that must not start
		////////////////////////////////////////////////////////////////////////
		phase           = 1;
		vertex_job_addr = make_addr(1'b0);
		vertex_job_req  = 1'b1;
		repeat (40) begin
			enabled     = ($urandom_range(1, 0) == 1);
			config_word = ($urandom_range(2, 0) == 0) ? '0 : {$urandom(), $urandom()};
			@(posedge clock);
			#1;
		end
		enabled     = 1'b1;
		config_word = {$urandom(), $urandom()} | 64'd1;
		@(posedge clock);
		#1;
		config_word      = '0;
		wed_valid        = 1'b1;
		wed_num_vertices = TOTAL_V;
		wed_num_edges    = TOTAL_E;
		@(posedge clock);
		#1;
		wed_valid = 1'b0;
		do begin
			@(posedge clock);
			#1;
		end while (!vertex_job_grant);
		vertex_job_req = 1'b0;

		phase = 2;
		fork
			run_client(1'b0, BOTH_COUNT, 0);
			run_client(1'b1, BOTH_COUNT, 0);
		join
		phase = 3;
		run_client(1'b0, SINGLE_COUNT, 2);
		run_client(1'b1, SINGLE_COUNT, 2);
		phase = 4;
		fork
			run_client(1'b0, RANDOM_COUNT, 3);
			run_client(1'b1, RANDOM_COUNT, 3);
		join

		// done must rise and then hold
		phase = 5;
		while (!cu_done) begin
			@(posedge clock);
			#1;
		end
		repeat (5) begin
			@(posedge clock);
			#1;
		end
		phase = 6;
		@(posedge clock);
		#1;
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
